/* Makefile */
SIM := obj_dir/Vtb_noc_block

.PHONY: all run clean

all: run

$(SIM): files.f $(wildcard rtl/*.sv verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_noc_block -f files.f

run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@! grep -q "Simulation finished: FAIL" sim.log
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* files.f */
rtl/backend_pkg.sv
rtl/backend_iface.sv
rtl/reset_stretch.sv
rtl/flush_fsm.sv
rtl/flush_timer.sv
rtl/flush_port.sv
rtl/noc_block_top.sv
verif/tb_clk_gen.sv
verif/noc_block_asserts.sv
verif/tb_noc_block.sv

/* rtl/backend_iface.sv */
// --------------------------------------------------------------------------
// Backend interface: registers config fields, assembles the status vector
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module backend_iface (
  input  wire                         rfnoc_chdr_clk,
  input  wire                         rst,
  input  backend_pkg::core_vec_t      rfnoc_core_config,
  output backend_pkg::core_vec_t      rfnoc_core_status,
  input  wire                         flush_active,
  input  wire                         flush_done,
  input  wire                         flush_timed_out,
  output logic                        flush_en,
  output backend_pkg::flush_timeout_t flush_timeout,
  output logic                        soft_rst_req
);

  logic flush_active_q;
  logic flush_done_q;
  logic flush_timed_out_q;

  // --------------------------------------------------------------------------
  // Config, infrastructure to block
  // --------------------------------------------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rst) begin
      flush_en      <= 1'b0;
      flush_timeout <= '0;
      soft_rst_req  <= 1'b0;
    end else begin
      flush_en      <= rfnoc_core_config[backend_pkg::BEC_FLUSH_EN_OFFSET];
      flush_timeout <= rfnoc_core_config[backend_pkg::BEC_FLUSH_TIMEOUT_OFFSET +:
                                         backend_pkg::BEC_FLUSH_TIMEOUT_WIDTH];
      soft_rst_req  <= rfnoc_core_config[backend_pkg::BEC_SOFT_RST_OFFSET];
    end
  end

  // --------------------------------------------------------------------------
  // Status, block to infrastructure
  // --------------------------------------------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rst) begin
      flush_active_q    <= 1'b0;
      flush_done_q      <= 1'b0;
      flush_timed_out_q <= 1'b0;
    end else begin
      flush_active_q    <= flush_active;
      flush_done_q      <= flush_done;
      flush_timed_out_q <= flush_timed_out;
    end
  end

  // Constant identity fields
  assign rfnoc_core_status[backend_pkg::BES_PROTO_VER_OFFSET +:
                           backend_pkg::BES_PROTO_VER_WIDTH] = backend_pkg::PROTO_VER;
  assign rfnoc_core_status[backend_pkg::BES_NUM_DATA_OFFSET +:
                           backend_pkg::BES_NUM_DATA_WIDTH] = backend_pkg::NUM_DATA;
  assign rfnoc_core_status[backend_pkg::BES_NOC_ID_OFFSET +:
                           backend_pkg::BES_NOC_ID_WIDTH] = backend_pkg::NOC_ID;
  assign rfnoc_core_status[backend_pkg::BES_DATA_MTU_OFFSET +:
                           backend_pkg::BES_DATA_MTU_WIDTH] = backend_pkg::MTU;

  // Flush flags, one cycle behind the state machine
  assign rfnoc_core_status[backend_pkg::BES_FLUSH_ACTIVE_OFFSET]    = flush_active_q;
  assign rfnoc_core_status[backend_pkg::BES_FLUSH_DONE_OFFSET]      = flush_done_q;
  assign rfnoc_core_status[backend_pkg::BES_FLUSH_TIMED_OUT_OFFSET] = flush_timed_out_q;

  // Unused upper bits
  assign rfnoc_core_status[backend_pkg::CORE_VEC_WIDTH-1:backend_pkg::BES_TOTAL_WIDTH] = '0;

endmodule

`default_nettype wire

/* rtl/backend_pkg.sv */
// --------------------------------------------------------------------------
// Backend package: config and status field layout, block constants, types
// --------------------------------------------------------------------------
`default_nettype none

package backend_pkg;

  // Block constants
  localparam int NUM_PORTS       = 2;
  localparam int PORT_DEPTH      = 4;
  localparam int PORT_PTR_WIDTH  = $clog2(PORT_DEPTH);
  localparam int RESET_LENGTH    = 32;
  localparam int RESET_CNT_WIDTH = $clog2(RESET_LENGTH + 1);
  localparam int CORE_VEC_WIDTH  = 512;

  localparam logic [7:0]  PROTO_VER = 8'd1;
  localparam logic [31:0] NOC_ID    = 32'h0B10_C0DE;
  localparam logic [5:0]  MTU       = 6'd10;

  // ------------------------------------------------------------------------
  // Config fields, infrastructure to block
  // ------------------------------------------------------------------------
  localparam int BEC_FLUSH_TIMEOUT_OFFSET = 0;
  localparam int BEC_FLUSH_TIMEOUT_WIDTH  = 32;
  localparam int BEC_FLUSH_EN_OFFSET      = 32;
  localparam int BEC_SOFT_RST_OFFSET      = 33;

  // ------------------------------------------------------------------------
  // Status fields, block to infrastructure
  // ------------------------------------------------------------------------
  localparam int BES_PROTO_VER_OFFSET       = 0;
  localparam int BES_PROTO_VER_WIDTH        = 8;
  localparam int BES_NUM_DATA_OFFSET        = 8;
  localparam int BES_NUM_DATA_WIDTH         = 6;
  localparam int BES_NOC_ID_OFFSET          = 14;
  localparam int BES_NOC_ID_WIDTH           = 32;
  localparam int BES_FLUSH_ACTIVE_OFFSET    = 46;
  localparam int BES_FLUSH_DONE_OFFSET      = 47;
  localparam int BES_DATA_MTU_OFFSET        = 48;
  localparam int BES_DATA_MTU_WIDTH         = 6;
  localparam int BES_FLUSH_TIMED_OUT_OFFSET = 54;
  localparam int BES_TOTAL_WIDTH            = 55;

  // Port count as it appears in the status field
  localparam logic [BES_NUM_DATA_WIDTH-1:0] NUM_DATA = BES_NUM_DATA_WIDTH'(NUM_PORTS);

  typedef logic [CORE_VEC_WIDTH-1:0]          core_vec_t;
  typedef logic [BEC_FLUSH_TIMEOUT_WIDTH-1:0] flush_timeout_t;
  typedef logic [31:0]                        port_data_t;
  typedef logic [NUM_PORTS-1:0]               port_mask_t;
  typedef logic [2:0]                         port_count_t;

  typedef enum logic [1:0] {
    FLUSH_IDLE,
    FLUSH_DRAIN,
    FLUSH_CLEAR,
    FLUSH_DONE
  } flush_state_t;

endpackage

`default_nettype wire

/* rtl/flush_fsm.sv */
// --------------------------------------------------------------------------
// Flush FSM: drains the data ports, clears them if the timeout runs out
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module flush_fsm (
  input  wire                     rfnoc_chdr_clk,
  input  wire                     rfnoc_chdr_rst,
  input  wire                     flush_en,
  input  backend_pkg::port_mask_t port_empty,
  input  wire                     timer_expired,
  output logic                    port_flush,
  output logic                    port_clear,
  output logic                    timer_start,
  output logic                    timer_cancel,
  output logic                    flush_active,
  output logic                    flush_done,
  output logic                    flush_timed_out
);

  backend_pkg::flush_state_t state;

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      state           <= backend_pkg::FLUSH_IDLE;
      timer_start     <= 1'b0;
      timer_cancel    <= 1'b0;
      flush_timed_out <= 1'b0;
    end else begin
      // Timer controls are single-cycle pulses
      timer_start  <= 1'b0;
      timer_cancel <= 1'b0;
      case (state)
        backend_pkg::FLUSH_IDLE: begin
          flush_timed_out <= 1'b0;
          if (flush_en) begin
            state       <= backend_pkg::FLUSH_DRAIN;
            timer_start <= 1'b1;
          end
        end
        backend_pkg::FLUSH_DRAIN: begin
          if (!flush_en) begin
            state        <= backend_pkg::FLUSH_IDLE;
            timer_cancel <= 1'b1;
          end else if (&port_empty) begin
            state        <= backend_pkg::FLUSH_DONE;
            timer_cancel <= 1'b1;
          end else if (timer_expired) begin
            state <= backend_pkg::FLUSH_CLEAR;
          end
        end
        backend_pkg::FLUSH_CLEAR: begin
          if (!flush_en) begin
            state <= backend_pkg::FLUSH_IDLE;
          end else begin
            state           <= backend_pkg::FLUSH_DONE;
            flush_timed_out <= 1'b1;
          end
        end
        backend_pkg::FLUSH_DONE: begin
          if (!flush_en) begin
            state           <= backend_pkg::FLUSH_IDLE;
            flush_timed_out <= 1'b0;
          end
        end
        default: state <= backend_pkg::FLUSH_IDLE;
      endcase
    end
  end

  // Ports keep dropping input until flush_en is released
  assign port_flush   = (state != backend_pkg::FLUSH_IDLE);
  assign port_clear   = (state == backend_pkg::FLUSH_CLEAR);
  assign flush_active = (state == backend_pkg::FLUSH_DRAIN) ||
                        (state == backend_pkg::FLUSH_CLEAR);
  assign flush_done   = (state == backend_pkg::FLUSH_DONE);

endmodule

`default_nettype wire

/* rtl/flush_port.sv */
// --------------------------------------------------------------------------
// Data port buffer: four-entry circular buffer with flush and clear
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module flush_port (
  input  wire                     rfnoc_chdr_clk,
  input  wire                     rfnoc_chdr_rst,
  input  wire                     in_valid,
  input  backend_pkg::port_data_t in_data,
  input  wire                     out_pop,
  output logic                    out_valid,
  output backend_pkg::port_data_t out_data,
  input  wire                     port_flush,
  input  wire                     port_clear,
  output logic                    port_empty
);

  backend_pkg::port_data_t                mem [backend_pkg::PORT_DEPTH];
  logic [backend_pkg::PORT_PTR_WIDTH-1:0] wr_ptr;
  logic [backend_pkg::PORT_PTR_WIDTH-1:0] rd_ptr;
  backend_pkg::port_count_t               count;
  logic                                   wr_en;
  logic                                   rd_en;

  // Input is dropped while flushing or full
  assign wr_en = in_valid && !port_flush &&
                 (count != backend_pkg::port_count_t'(backend_pkg::PORT_DEPTH));
  assign rd_en = out_pop && (count != '0);

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst || port_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Fill count tracks both sides in the same cycle
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign out_valid  = (count != '0);
  assign out_data   = mem[rd_ptr];
  assign port_empty = (count == '0);

endmodule

`default_nettype wire

/* rtl/flush_timer.sv */
// --------------------------------------------------------------------------
// Flush timer: counts the timeout down and pulses once on expiry
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module flush_timer (
  input  wire                         rfnoc_chdr_clk,
  input  wire                         rfnoc_chdr_rst,
  input  wire                         timer_start,
  input  wire                         timer_cancel,
  input  backend_pkg::flush_timeout_t flush_timeout,
  output logic                        timer_expired
);

  backend_pkg::flush_timeout_t count;
  logic                        armed;

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      count         <= '0;
      armed         <= 1'b0;
      timer_expired <= 1'b0;
    end else begin
      timer_expired <= 1'b0;
      if (timer_cancel) begin
        armed <= 1'b0;
      end else if (timer_start) begin
        count <= flush_timeout;
        armed <= 1'b1;
      end else if (armed) begin
        // Zero reached, fire once and disarm
        if (count == '0) begin
          armed         <= 1'b0;
          timer_expired <= 1'b1;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/noc_block_top.sv */
// --------------------------------------------------------------------------
// Block top: backend interface, reset stretcher, flush control, data ports
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module noc_block_top (
  input  wire                                                 rfnoc_chdr_clk,
  input  wire                                                 rst,
  input  backend_pkg::core_vec_t                              rfnoc_core_config,
  output backend_pkg::core_vec_t                              rfnoc_core_status,
  output logic                                                rfnoc_chdr_rst,
  input  backend_pkg::port_mask_t                             in_valid,
  input  backend_pkg::port_data_t [backend_pkg::NUM_PORTS-1:0] in_data,
  input  backend_pkg::port_mask_t                             out_pop,
  output backend_pkg::port_mask_t                             out_valid,
  output backend_pkg::port_data_t [backend_pkg::NUM_PORTS-1:0] out_data
);

  logic                        flush_en;
  backend_pkg::flush_timeout_t flush_timeout;
  logic                        soft_rst_req;
  logic                        flush_active;
  logic                        flush_done;
  logic                        flush_timed_out;
  logic                        port_flush;
  logic                        port_clear;
  logic                        timer_start;
  logic                        timer_cancel;
  logic                        timer_expired;
  backend_pkg::port_mask_t     port_empty;

  backend_iface u_backend_iface (
    .rfnoc_chdr_clk    (rfnoc_chdr_clk),
    .rst               (rst),
    .rfnoc_core_config (rfnoc_core_config),
    .rfnoc_core_status (rfnoc_core_status),
    .flush_active      (flush_active),
    .flush_done        (flush_done),
    .flush_timed_out   (flush_timed_out),
    .flush_en          (flush_en),
    .flush_timeout     (flush_timeout),
    .soft_rst_req      (soft_rst_req)
  );

  reset_stretch u_reset_stretch (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rst            (rst),
    .soft_rst_req   (soft_rst_req),
    .rfnoc_chdr_rst (rfnoc_chdr_rst)
  );

  flush_fsm u_flush_fsm (
    .rfnoc_chdr_clk  (rfnoc_chdr_clk),
    .rfnoc_chdr_rst  (rfnoc_chdr_rst),
    .flush_en        (flush_en),
    .port_empty      (port_empty),
    .timer_expired   (timer_expired),
    .port_flush      (port_flush),
    .port_clear      (port_clear),
    .timer_start     (timer_start),
    .timer_cancel    (timer_cancel),
    .flush_active    (flush_active),
    .flush_done      (flush_done),
    .flush_timed_out (flush_timed_out)
  );

  flush_timer u_flush_timer (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .timer_start    (timer_start),
    .timer_cancel   (timer_cancel),
    .flush_timeout  (flush_timeout),
    .timer_expired  (timer_expired)
  );

  // One buffer per data port, all sharing the flush controls
  for (genvar i = 0; i < backend_pkg::NUM_PORTS; i++) begin : g_port
    flush_port u_flush_port (
      .rfnoc_chdr_clk (rfnoc_chdr_clk),
      .rfnoc_chdr_rst (rfnoc_chdr_rst),
      .in_valid       (in_valid[i]),
      .in_data        (in_data[i]),
      .out_pop        (out_pop[i]),
      .out_valid      (out_valid[i]),
      .out_data       (out_data[i]),
      .port_flush     (port_flush),
      .port_clear     (port_clear),
      .port_empty     (port_empty[i])
    );
  end

endmodule

`default_nettype wire

/* rtl/reset_stretch.sv */
// --------------------------------------------------------------------------
// Reset stretcher: soft reset request edge to a fixed-length block reset
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module reset_stretch (
  input  wire  rfnoc_chdr_clk,
  input  wire  rst,
  input  wire  soft_rst_req,
  output logic rfnoc_chdr_rst
);

  logic                                   soft_rst_dly;
  logic                                   soft_rst_edge;
  logic [backend_pkg::RESET_CNT_WIDTH-1:0] rst_count;

  assign soft_rst_edge = soft_rst_req & ~soft_rst_dly;

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rst) begin
      soft_rst_dly <= 1'b0;
      rst_count    <= '0;
    end else begin
      soft_rst_dly <= soft_rst_req;
      // A new edge restarts the full length
      if (soft_rst_edge) begin
        rst_count <= backend_pkg::RESET_CNT_WIDTH'(backend_pkg::RESET_LENGTH);
      end else if (rst_count != '0) begin
        rst_count <= rst_count - 1'b1;
      end
    end
  end

  // Hard reset passes straight through
  assign rfnoc_chdr_rst = rst | (rst_count != '0);

endmodule

`default_nettype wire

/* verif/noc_block_asserts.sv */
// --------------------------------------------------------------------------
// Assertions bound to the block top for flush flags, soft reset and ports
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module noc_block_asserts (
  input wire                     rfnoc_chdr_clk,
  input wire                     rst,
  input wire                     rfnoc_chdr_rst,
  input wire                     soft_rst_req,
  input backend_pkg::core_vec_t  rfnoc_core_status,
  input wire                     port_flush,
  input backend_pkg::port_mask_t out_valid
);

  logic soft_rst_q;
  int   stretch_left;

  // Reset cycles still owed after a soft reset request edge
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rst) begin
      soft_rst_q   <= 1'b0;
      stretch_left <= 0;
    end else begin
      soft_rst_q <= soft_rst_req;
      if (soft_rst_req && !soft_rst_q) begin
        stretch_left <= backend_pkg::RESET_LENGTH;
      end else if (stretch_left != 0) begin
        stretch_left <= stretch_left - 1;
      end
    end
  end

  // Status flags as the infrastructure sees them in the packed vector
  a_flush_flags_exclusive: assert property (@(posedge rfnoc_chdr_clk)
    disable iff (rst)
    !(rfnoc_core_status[backend_pkg::BES_FLUSH_ACTIVE_OFFSET] &&
      rfnoc_core_status[backend_pkg::BES_FLUSH_DONE_OFFSET]))
    else $error("flush active and flush done status bits high together");

  a_soft_rst_held: assert property (@(posedge rfnoc_chdr_clk)
    disable iff (rst) (stretch_left != 0) |-> rfnoc_chdr_rst)
    else $error("rfnoc_chdr_rst dropped before the full soft reset length");

  a_soft_rst_ends: assert property (@(posedge rfnoc_chdr_clk)
    disable iff (rst) (stretch_left == 0 && $past(stretch_left) == 1) |-> !rfnoc_chdr_rst)
    else $error("rfnoc_chdr_rst held past the soft reset length");

  // A word already accepted may show up on the first flush cycle only
  a_no_word_during_flush: assert property (@(posedge rfnoc_chdr_clk)
    disable iff (rfnoc_chdr_rst) (port_flush && $past(port_flush)) |->
    ((out_valid & ~$past(out_valid)) == '0))
    else $error("out_valid rose while the ports were flushing");

endmodule

bind noc_block_top noc_block_asserts u_asserts (
  .rfnoc_chdr_clk    (rfnoc_chdr_clk),
  .rst               (rst),
  .rfnoc_chdr_rst    (rfnoc_chdr_rst),
  .soft_rst_req      (soft_rst_req),
  .rfnoc_core_status (rfnoc_core_status),
  .port_flush        (port_flush),
  .out_valid         (out_valid)
);

`default_nettype wire

/* verif/tb_clk_gen.sv */
// --------------------------------------------------------------------------
// Testbench clock generator, free running from time zero
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

/* verif/tb_noc_block.sv */
// --------------------------------------------------------------------------
// Table-driven testbench for the block top with a model of the port buffers
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_noc_block;

  typedef enum logic [2:0] {OP_STATUS, OP_TRAFFIC, OP_FLUSH, OP_UNFLUSH, OP_SOFT_RST} op_t;

  typedef struct packed {
    op_t                         op;
    backend_pkg::flush_timeout_t timeout;
    logic [3:0]                  cycles;
    backend_pkg::port_mask_t     wr;
    backend_pkg::port_mask_t     pop;
    logic                        exp_timed_out;
  } row_t;

  localparam int ROW_COUNT    = 17;
  localparam int RST_CYCLES   = 16;
  localparam int LONG_TIMEOUT = 64;
  localparam int CYCLE_LIMIT  = RST_CYCLES + ROW_COUNT * 16 + 2 * (LONG_TIMEOUT + 16) +
                                2 * backend_pkg::RESET_LENGTH;

  logic                                                 clk;
  logic                                                 rst;
  backend_pkg::core_vec_t                               rfnoc_core_config;
  backend_pkg::core_vec_t                               rfnoc_core_status;
  logic                                                 rfnoc_chdr_rst;
  backend_pkg::port_mask_t                              in_valid;
  backend_pkg::port_data_t [backend_pkg::NUM_PORTS-1:0] in_data;
  backend_pkg::port_mask_t                              out_pop;
  backend_pkg::port_mask_t                              out_valid;
  backend_pkg::port_data_t [backend_pkg::NUM_PORTS-1:0] out_data;

  backend_pkg::core_vec_t  cfg;
  row_t                    rows [ROW_COUNT];
  backend_pkg::port_data_t model_q [backend_pkg::NUM_PORTS][$];
  logic                    blocked;
  logic                    track_ports;
  integer                  seed = 16;
  int                      error_count = 0;
  int                      check_count = 0;
  int                      cycle_count = 0;
  int                      high_cycles;

  tb_clk_gen #(.PERIOD_NS(40)) u_clk_gen (.clk(clk));

  noc_block_top u_dut (
    .rfnoc_chdr_clk    (clk),
    .rst               (rst),
    .rfnoc_core_config (rfnoc_core_config),
    .rfnoc_core_status (rfnoc_core_status),
    .rfnoc_chdr_rst    (rfnoc_chdr_rst),
    .in_valid          (in_valid),
    .in_data           (in_data),
    .out_pop           (out_pop),
    .out_valid         (out_valid),
    .out_data          (out_data)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, a wait for the DUT never ended", cycle_count);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  // --------------------------------------------------------------------------
  // One clock cycle of stimulus, output checks and model update
  // --------------------------------------------------------------------------
  task automatic step(input backend_pkg::port_mask_t wr, input backend_pkg::port_mask_t pop);
    backend_pkg::port_data_t word [backend_pkg::NUM_PORTS];
    logic                    full;
    @(posedge clk);
    rfnoc_core_config <= cfg;
    in_valid          <= wr;
    out_pop           <= pop;
    for (int i = 0; i < backend_pkg::NUM_PORTS; i++) begin
      word[i]    = $random(seed);
      in_data[i] <= word[i];
    end
    @(negedge clk);
    for (int i = 0; i < backend_pkg::NUM_PORTS; i++) begin
      if (track_ports) begin
        check_value($sformatf("out_valid[%0d]", i), out_valid[i], model_q[i].size() != 0);
        if (model_q[i].size() != 0) begin
          check_value($sformatf("out_data[%0d]", i), out_data[i], model_q[i][0]);
        end
      end
      // Full is judged before the pop of the same edge
      full = (model_q[i].size() >= backend_pkg::PORT_DEPTH);
      if (pop[i] && model_q[i].size() != 0) begin
        void'(model_q[i].pop_front());
      end
      if (wr[i] && !blocked && !full) begin
        model_q[i].push_back(word[i]);
      end
    end
  endtask

  task automatic check_status();
    backend_pkg::core_vec_t s;
    step('0, '0);
    s = rfnoc_core_status;
    check_value("status.proto_ver", s[7:0], 8'd1);
    check_value("status.num_data", s[13:8], backend_pkg::NUM_PORTS);
    check_value("status.noc_id", s[45:14], backend_pkg::NOC_ID);
    check_value("status.mtu", s[53:48], backend_pkg::MTU);
    check_value("status.flush_active", s[46], 1'b0);
    check_value("status.flush_done", s[47], 1'b0);
    check_value("status.flush_timed_out", s[54], 1'b0);
    check_value("status.upper_bits_or", |s[511:55], 1'b0);
  endtask

  task automatic flush_ports(input row_t r);
    cfg[31:0] = r.timeout;
    cfg[32]   = 1'b1;
    // The clear pulse empties the ports at a point the model does not follow
    track_ports = !r.exp_timed_out;
    while (!rfnoc_core_status[46] && !rfnoc_core_status[47]) begin
      step('0, r.pop);
    end
    check_value("status.flush_active", rfnoc_core_status[46], 1'b1);
    blocked = 1'b1;
    while (!rfnoc_core_status[47]) begin
      step('1, r.pop);
    end
    check_value("status.flush_timed_out", rfnoc_core_status[54], r.exp_timed_out);
    check_value("status.flush_active", rfnoc_core_status[46], 1'b0);
    for (int i = 0; i < backend_pkg::NUM_PORTS; i++) begin
      if (r.exp_timed_out) begin
        model_q[i].delete();
      end
      check_value($sformatf("out_valid[%0d]", i), out_valid[i], 1'b0);
    end
    track_ports = 1'b1;
  endtask

  task automatic release_flush();
    cfg[32] = 1'b0;
    while (rfnoc_core_status[46] || rfnoc_core_status[47] || rfnoc_core_status[54]) begin
      step('0, '0);
    end
    blocked = 1'b0;
  endtask

  task automatic pulse_soft_reset();
    cfg[33] = 1'b1;
    step('0, '0);
    step('0, '0);
    step('0, '0);
    // Block reset starts two cycles after the config change
    check_value("rfnoc_chdr_rst", rfnoc_chdr_rst, 1'b1);
    for (int i = 0; i < backend_pkg::NUM_PORTS; i++) begin
      model_q[i].delete();
    end
    high_cycles = 0;
    while (rfnoc_chdr_rst) begin
      high_cycles++;
      step('0, '0);
    end
    check_value("rfnoc_chdr_rst cycles", high_cycles, backend_pkg::RESET_LENGTH);
    cfg[33] = 1'b0;
    step('0, '0);
  endtask

  initial begin
    rst               = 1'b1;
    cfg               = '0;
    rfnoc_core_config = '0;
    in_valid          = '0;
    in_data           = '0;
    out_pop           = '0;
    blocked           = 1'b0;
    track_ports       = 1'b1;

    //         op           timeout            cyc   wr     pop    timed out
    rows[0]  = '{OP_STATUS,   32'd0,            4'd0, 2'b00, 2'b00, 1'b0};
    rows[1]  = '{OP_TRAFFIC,  32'd0,            4'd6, 2'b11, 2'b00, 1'b0};
    rows[2]  = '{OP_TRAFFIC,  32'd0,            4'd6, 2'b00, 2'b11, 1'b0};
    rows[3]  = '{OP_TRAFFIC,  32'd0,            4'd8, 2'b11, 2'b01, 1'b0};
    rows[4]  = '{OP_TRAFFIC,  32'd0,            4'd3, 2'b01, 2'b00, 1'b0};
    rows[5]  = '{OP_FLUSH,    32'(LONG_TIMEOUT), 4'd0, 2'b00, 2'b11, 1'b0};
    rows[6]  = '{OP_UNFLUSH,  32'd0,            4'd0, 2'b00, 2'b00, 1'b0};
    rows[7]  = '{OP_STATUS,   32'd0,            4'd0, 2'b00, 2'b00, 1'b0};
    rows[8]  = '{OP_TRAFFIC,  32'd0,            4'd5, 2'b11, 2'b00, 1'b0};
    rows[9]  = '{OP_FLUSH,    32'd3,            4'd0, 2'b00, 2'b00, 1'b1};
    rows[10] = '{OP_UNFLUSH,  32'd0,            4'd0, 2'b00, 2'b00, 1'b0};
    rows[11] = '{OP_TRAFFIC,  32'd0,            4'd4, 2'b11, 2'b10, 1'b0};
    rows[12] = '{OP_TRAFFIC,  32'd0,            4'd5, 2'b00, 2'b11, 1'b0};
    rows[13] = '{OP_TRAFFIC,  32'd0,            4'd3, 2'b11, 2'b00, 1'b0};
    rows[14] = '{OP_SOFT_RST, 32'd0,            4'd0, 2'b00, 2'b00, 1'b0};
    rows[15] = '{OP_STATUS,   32'd0,            4'd0, 2'b00, 2'b00, 1'b0};
    rows[16] = '{OP_TRAFFIC,  32'd0,            4'd4, 2'b11, 2'b11, 1'b0};

    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    for (int r = 0; r < ROW_COUNT; r++) begin
      case (rows[r].op)
        OP_STATUS:   check_status();
        OP_FLUSH:    flush_ports(rows[r]);
        OP_UNFLUSH:  release_flush();
        OP_SOFT_RST: pulse_soft_reset();
        default: begin
          for (int c = 0; c < rows[r].cycles; c++) begin
            step(rows[r].wr, rows[r].pop);
          end
        end
      endcase
    end

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
